/* hw/id_pkg.sv */
package id_pkg;

	// word and address width of the core
	localparam int XLEN = 32;

	typedef enum logic [5:0] {
		OP_SPECIAL  = 6'h00,
		OP_REGIMM   = 6'h01,
		OP_J        = 6'h02,
		OP_JAL      = 6'h03,
		OP_BEQ      = 6'h04,
		OP_BNE      = 6'h05,
		OP_BLEZ     = 6'h06,
		OP_BGTZ     = 6'h07,
		OP_ADDI     = 6'h08,
		OP_ADDIU    = 6'h09,
		OP_SLTI     = 6'h0a,
		OP_SLTIU    = 6'h0b,
		OP_ANDI     = 6'h0c,
		OP_ORI      = 6'h0d,
		OP_XORI     = 6'h0e,
		OP_LUI      = 6'h0f,
		OP_SPECIAL2 = 6'h1c,
		OP_LB       = 6'h20,
		OP_LH       = 6'h21,
		OP_LW       = 6'h23,
		OP_LBU      = 6'h24,
		OP_LHU      = 6'h25,
		OP_SB       = 6'h28,
		OP_SH       = 6'h29,
		OP_SW       = 6'h2b,
		OP_PREF     = 6'h33
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL     = 6'h00,
		FN_SRL     = 6'h02,
		FN_SRA     = 6'h03,
		FN_SLLV    = 6'h04,
		FN_SRLV    = 6'h06,
		FN_SRAV    = 6'h07,
		FN_JR      = 6'h08,
		FN_JALR    = 6'h09,
		FN_SYSCALL = 6'h0c,
		FN_BREAK   = 6'h0d,
		FN_SYNC    = 6'h0f,
		FN_MFHI    = 6'h10,
		FN_MTHI    = 6'h11,
		FN_MFLO    = 6'h12,
		FN_MTLO    = 6'h13,
		FN_MULT    = 6'h18,
		FN_MULTU   = 6'h19,
		FN_DIV     = 6'h1a,
		FN_DIVU    = 6'h1b,
		FN_ADD     = 6'h20,
		FN_ADDU    = 6'h21,
		FN_SUB     = 6'h22,
		FN_SUBU    = 6'h23,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_XOR     = 6'h26,
		FN_NOR     = 6'h27,
		FN_SLT     = 6'h2a,
		FN_SLTU    = 6'h2b
	} func_e;

	// special2 MUL has the same function code as SRL
	localparam logic [5:0] FN2_MUL = 6'h02;

	typedef enum logic [4:0] {
		RT_BLTZ   = 5'h00,
		RT_BGEZ   = 5'h01,
		RT_BLTZAL = 5'h10,
		RT_BGEZAL = 5'h11
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP = 8'h00,
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
		ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU,
		ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LU,
		ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_SB, ALU_SH, ALU_SW,
		ALU_JALR, ALU_MFHI, ALU_MTHI, ALU_MFLO, ALU_MTLO,
		ALU_MULT, ALU_MULTU, ALU_MUL
	} alu_op_e;

	typedef enum logic [3:0] {LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW} load_type_e;
	typedef enum logic [3:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_type_e;
	typedef enum logic [1:0] {RES_MEM = 2'b00, RES_ALU = 2'b01} result_sel_e;
	typedef enum logic [1:0] {SRC1_RT, SRC1_HI, SRC1_LO, SRC1_IMM} src1_sel_e;
	// link writes go to r31
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regdst_e;

	typedef struct packed {
		logic brk;
		logic sys;
		logic ri;
	} exc_t;

	typedef struct packed {
		logic        wreg;
		logic        wmem;
		logic        whi;
		logic        wlo;
		logic        hi_i_sel;
		logic        lo_i_sel;
		logic        is_div;
		logic        is_sign_div;
		logic        sign;
		logic        alusrc0_sel;
		src1_sel_e   alusrc1_sel;
		regdst_e     regdst;
		result_sel_e result_sel;
		load_type_e  load_type;
		store_type_e store_type;
	} ctrl_t;

	typedef struct packed {
		logic            i_bj;
		logic            i_b;
		logic            taken;
		logic [XLEN-1:0] target;
	} bj_t;

	// inactive control word, immediates sign extend by default
	localparam ctrl_t CTRL_IDLE = '{
		sign:        1'b1,
		alusrc1_sel: SRC1_RT,
		regdst:      DST_RT,
		result_sel:  RES_MEM,
		load_type:   LD_NONE,
		store_type:  ST_NONE,
		default:     1'b0
	};

endpackage

/* hw/alu_op_decode.sv */
module alu_op_decode (
	input  logic [31:0]     i_inst,
	output id_pkg::alu_op_e o_alu_op,
	output id_pkg::exc_t    o_exc
);
	import id_pkg::*;

	opcode_e    op;
	func_e      fn;
	logic [4:0] rs;
	logic [4:0] rt;

	assign op = opcode_e'(i_inst[31:26]);
	assign fn = func_e'(i_inst[5:0]);
	assign rs = i_inst[25:21];
	assign rt = i_inst[20:16];

	always_comb
	begin
		o_alu_op = ALU_NOP;
		o_exc    = '0;
		case (op)
			// plain jumps, branches and prefetch need no ALU work
			OP_J, OP_BEQ, OP_BNE, OP_PREF:
				o_alu_op = ALU_NOP;
			OP_JAL:
				o_alu_op = ALU_JALR;
			OP_BLEZ, OP_BGTZ:
				o_exc.ri = |rt;
			OP_ADDI:  o_alu_op = ALU_ADDI;
			OP_ADDIU: o_alu_op = ALU_ADDIU;
			OP_SLTI:  o_alu_op = ALU_SLTI;
			OP_SLTIU: o_alu_op = ALU_SLTIU;
			OP_ANDI:  o_alu_op = ALU_ANDI;
			OP_ORI:   o_alu_op = ALU_ORI;
			OP_XORI:  o_alu_op = ALU_XORI;
			OP_LUI:
			begin
				o_alu_op = ALU_LU;
				o_exc.ri = |rs;
			end
			OP_LB:  o_alu_op = ALU_LB;
			OP_LBU: o_alu_op = ALU_LBU;
			OP_LH:  o_alu_op = ALU_LH;
			OP_LHU: o_alu_op = ALU_LHU;
			OP_LW:  o_alu_op = ALU_LW;
			OP_SB:  o_alu_op = ALU_SB;
			OP_SH:  o_alu_op = ALU_SH;
			OP_SW:  o_alu_op = ALU_SW;
			OP_REGIMM:
			begin
				case (regimm_e'(rt))
					RT_BLTZ, RT_BGEZ:     o_alu_op = ALU_NOP;
					// link forms compute the return address
					RT_BLTZAL, RT_BGEZAL: o_alu_op = ALU_JALR;
					default:              o_exc.ri = 1'b1;
				endcase
			end
			OP_SPECIAL2:
			begin
				if (fn == FN2_MUL)
					o_alu_op = ALU_MUL;
				else
					o_exc.ri = 1'b1;
			end
			OP_SPECIAL:
			begin
				case (fn)
					FN_SLL:     o_alu_op = ALU_SLL;
					FN_SRL:     o_alu_op = ALU_SRL;
					FN_SRA:     o_alu_op = ALU_SRA;
					FN_SLLV:    o_alu_op = ALU_SLLV;
					FN_SRLV:    o_alu_op = ALU_SRLV;
					FN_SRAV:    o_alu_op = ALU_SRAV;
					FN_JR:      o_alu_op = ALU_NOP;
					FN_JALR:    o_alu_op = ALU_JALR;
					FN_SYSCALL: o_exc.sys = 1'b1;
					FN_BREAK:   o_exc.brk = 1'b1;
					FN_SYNC:    o_alu_op = ALU_NOP;
					FN_MFHI:    o_alu_op = ALU_MFHI;
					FN_MTHI:    o_alu_op = ALU_MTHI;
					FN_MFLO:    o_alu_op = ALU_MFLO;
					FN_MTLO:    o_alu_op = ALU_MTLO;
					FN_MULT:    o_alu_op = ALU_MULT;
					FN_MULTU:   o_alu_op = ALU_MULTU;
					// divider is started from the control word alone
					FN_DIV, FN_DIVU:
						o_alu_op = ALU_NOP;
					FN_ADD:     o_alu_op = ALU_ADD;
					FN_ADDU:    o_alu_op = ALU_ADDU;
					FN_SUB:     o_alu_op = ALU_SUB;
					FN_SUBU:    o_alu_op = ALU_SUBU;
					FN_AND:     o_alu_op = ALU_AND;
					FN_OR:      o_alu_op = ALU_OR;
					FN_XOR:     o_alu_op = ALU_XOR;
					FN_NOR:     o_alu_op = ALU_NOR;
					FN_SLT:     o_alu_op = ALU_SLT;
					FN_SLTU:    o_alu_op = ALU_SLTU;
					default:    o_exc.ri = 1'b1;
				endcase
			end
			// cop0, traps, ll/sc and unaligned accesses land here too
			default:
				o_exc.ri = 1'b1;
		endcase
	end

endmodule

/* hw/ctrl_decode.sv */
module ctrl_decode (
	input  logic [31:0]   i_inst,
	output id_pkg::ctrl_t o_ctrl
);
	import id_pkg::*;

	opcode_e op;
	func_e   fn;
	regimm_e rt;

	assign op = opcode_e'(i_inst[31:26]);
	assign fn = func_e'(i_inst[5:0]);
	assign rt = regimm_e'(i_inst[20:16]);

	always_comb
	begin
		o_ctrl = CTRL_IDLE;
		case (op)
			// logical immediates are zero extended
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				o_ctrl.wreg        = 1'b1;
				o_ctrl.result_sel  = RES_ALU;
				o_ctrl.sign        = 1'b0;
				o_ctrl.alusrc1_sel = SRC1_IMM;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
			begin
				o_ctrl.wreg        = 1'b1;
				o_ctrl.result_sel  = RES_ALU;
				o_ctrl.alusrc1_sel = SRC1_IMM;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
			begin
				o_ctrl.wreg        = 1'b1;
				o_ctrl.alusrc1_sel = SRC1_IMM;
				case (op)
					OP_LB:   o_ctrl.load_type = LD_LB;
					OP_LBU:  o_ctrl.load_type = LD_LBU;
					OP_LH:   o_ctrl.load_type = LD_LH;
					OP_LHU:  o_ctrl.load_type = LD_LHU;
					default: o_ctrl.load_type = LD_LW;
				endcase
			end
			OP_SB, OP_SH, OP_SW:
			begin
				o_ctrl.wmem        = 1'b1;
				o_ctrl.alusrc1_sel = SRC1_IMM;
				case (op)
					OP_SB:   o_ctrl.store_type = ST_SB;
					OP_SH:   o_ctrl.store_type = ST_SH;
					default: o_ctrl.store_type = ST_SW;
				endcase
			end
			OP_JAL:
			begin
				o_ctrl.wreg       = 1'b1;
				o_ctrl.result_sel = RES_ALU;
				o_ctrl.regdst     = DST_RA;
			end
			OP_REGIMM:
			begin
				if (rt == RT_BLTZAL || rt == RT_BGEZAL)
				begin
					o_ctrl.wreg       = 1'b1;
					o_ctrl.result_sel = RES_ALU;
					o_ctrl.regdst     = DST_RA;
				end
			end
			OP_SPECIAL2:
			begin
				if (fn == FN2_MUL)
				begin
					o_ctrl.wreg       = 1'b1;
					o_ctrl.result_sel = RES_ALU;
					o_ctrl.regdst     = DST_RD;
				end
			end
			OP_SPECIAL:
			begin
				case (fn)
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
					FN_SLLV, FN_SRLV, FN_SRAV, FN_JALR:
					begin
						o_ctrl.wreg       = 1'b1;
						o_ctrl.result_sel = RES_ALU;
						o_ctrl.regdst     = DST_RD;
					end
					// shift amount comes from the sa field
					FN_SLL, FN_SRL, FN_SRA:
					begin
						o_ctrl.wreg        = 1'b1;
						o_ctrl.result_sel  = RES_ALU;
						o_ctrl.alusrc0_sel = 1'b1;
						o_ctrl.regdst      = DST_RD;
					end
					FN_MFHI, FN_MFLO:
					begin
						o_ctrl.wreg        = 1'b1;
						o_ctrl.result_sel  = RES_ALU;
						o_ctrl.alusrc1_sel = (fn == FN_MFHI) ? SRC1_HI : SRC1_LO;
						o_ctrl.regdst      = DST_RD;
					end
					FN_MTHI, FN_MTLO:
					begin
						o_ctrl.whi        = (fn == FN_MTHI);
						o_ctrl.wlo        = (fn == FN_MTLO);
						o_ctrl.result_sel = RES_ALU;
					end
					// hi/lo take the 64-bit unit result
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:
					begin
						o_ctrl.hi_i_sel    = 1'b1;
						o_ctrl.lo_i_sel    = 1'b1;
						o_ctrl.whi         = 1'b1;
						o_ctrl.wlo         = 1'b1;
						o_ctrl.is_div      = (fn == FN_DIV || fn == FN_DIVU);
						o_ctrl.is_sign_div = (fn == FN_DIV);
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	assert property (@(o_ctrl) !(o_ctrl.wreg && o_ctrl.wmem))
		else $error("ctrl_decode: wreg and wmem both set");
	assert property (@(o_ctrl) o_ctrl.is_div |-> (o_ctrl.whi && o_ctrl.wlo))
		else $error("ctrl_decode: divide without hi/lo write");

endmodule

/* hw/branch_unit.sv */
module branch_unit #(
	parameter int DATA_W = id_pkg::XLEN
) (
	input  logic [31:0]       i_inst,
	input  logic [DATA_W-1:0] i_pc_plus4,
	input  logic [DATA_W-1:0] i_rs_data,
	input  logic [DATA_W-1:0] i_rt_data,
	output id_pkg::bj_t       o_bj
);
	import id_pkg::*;

	opcode_e           op;
	func_e             fn;
	regimm_e           rt;
	logic [15:0]       offset;
	logic [DATA_W-1:0] b_tgt;
	logic [DATA_W-1:0] j_tgt;
	logic              rs_eq_rt;
	logic              rs_zero;
	logic              rs_neg;
	logic              b_cond;

	assign op     = opcode_e'(i_inst[31:26]);
	assign fn     = func_e'(i_inst[5:0]);
	assign rt     = regimm_e'(i_inst[20:16]);
	assign offset = i_inst[15:0];

	assign b_tgt = i_pc_plus4 + {{(DATA_W-18){offset[15]}}, offset, 2'b00};
	// region jump keeps the top bits of pc+4
	assign j_tgt = {i_pc_plus4[DATA_W-1:28], i_inst[25:0], 2'b00};

	assign rs_eq_rt = (i_rs_data == i_rt_data);
	assign rs_zero  = ~|i_rs_data;
	assign rs_neg   = i_rs_data[DATA_W-1];

	always_comb
	begin
		case (op)
			OP_BEQ:  b_cond = rs_eq_rt;
			OP_BNE:  b_cond = !rs_eq_rt;
			OP_BLEZ: b_cond = rs_neg || rs_zero;
			OP_BGTZ: b_cond = !rs_neg && !rs_zero;
			// regimm forms, rt bit 0 picks the GEZ variants
			default: b_cond = i_inst[16] ? !rs_neg : rs_neg;
		endcase
	end

	always_comb
	begin
		o_bj = '0;
		case (op)
			OP_J, OP_JAL:
			begin
				o_bj.i_bj   = 1'b1;
				o_bj.taken  = 1'b1;
				o_bj.target = j_tgt;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
			begin
				o_bj.i_bj   = 1'b1;
				o_bj.i_b    = 1'b1;
				o_bj.taken  = b_cond;
				o_bj.target = b_tgt;
			end
			OP_REGIMM:
			begin
				if (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL})
				begin
					o_bj.i_bj   = 1'b1;
					o_bj.i_b    = 1'b1;
					o_bj.taken  = b_cond;
					o_bj.target = b_tgt;
				end
			end
			OP_SPECIAL:
			begin
				// register jumps are flagged like branches for the fetch stage
				if (fn == FN_JR || fn == FN_JALR)
				begin
					o_bj.i_bj   = 1'b1;
					o_bj.i_b    = 1'b1;
					o_bj.taken  = 1'b1;
					o_bj.target = i_rs_data;
				end
			end
			default: ;
		endcase
	end

	assert property (@(o_bj) o_bj.taken |-> o_bj.i_bj)
		else $error("branch_unit: taken without branch or jump");

endmodule

/* hw/id_stage.sv */
module id_stage #(
	parameter int DATA_W = id_pkg::XLEN
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  logic [31:0]       i_inst,
	input  logic [DATA_W-1:0] i_pc_plus4,
	input  logic [DATA_W-1:0] i_rs_data,
	input  logic [DATA_W-1:0] i_rt_data,
	input  logic              i_delayslot,
	output logic              o_valid,
	output id_pkg::alu_op_e   o_alu_op,
	output id_pkg::ctrl_t     o_ctrl,
	output id_pkg::bj_t       o_bj,
	output id_pkg::exc_t      o_exc,
	output logic              o_delayslot
);
	import id_pkg::*;

	// decoder outputs, before the ID/EX register
	alu_op_e alu_op;
	exc_t    exc;
	ctrl_t   ctrl;
	bj_t     bj;

	alu_op_decode u_alu_op_decode (
		.i_inst   (i_inst),
		.o_alu_op (alu_op),
		.o_exc    (exc)
	);

	ctrl_decode u_ctrl_decode (
		.i_inst (i_inst),
		.o_ctrl (ctrl)
	);

	branch_unit #(
		.DATA_W (DATA_W)
	) u_branch_unit (
		.i_inst     (i_inst),
		.i_pc_plus4 (i_pc_plus4),
		.i_rs_data  (i_rs_data),
		.i_rt_data  (i_rt_data),
		.o_bj       (bj)
	);

	// ID/EX register
	// a bubble loads the same idle word as reset
	always_ff @(posedge clk)
	begin
		if (!rst_n || !i_valid)
		begin
			o_valid     <= 1'b0;
			o_alu_op    <= ALU_NOP;
			o_ctrl      <= CTRL_IDLE;
			o_bj        <= '0;
			o_exc       <= '0;
			o_delayslot <= 1'b0;
		end
		else
		begin
			o_valid     <= 1'b1;
			o_alu_op    <= alu_op;
			o_ctrl      <= ctrl;
			o_bj        <= bj;
			o_exc       <= exc;
			o_delayslot <= i_delayslot;
		end
	end

	// at most one exception cause reaches execute
	assert property (@(posedge clk) disable iff (!rst_n) o_valid |-> $onehot0(o_exc))
		else $error("id_stage: more than one exception flag set");

endmodule

/* bench/id_model.svh */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// expected contents of the ID/EX register for one cycle
typedef struct packed {
	logic    valid;
	alu_op_e alu_op;
	ctrl_t   ctrl;
	bj_t     bj;
	exc_t    exc;
	logic    delayslot;
} id_out_t;

// reset and bubble leave only sign set
function automatic id_out_t idle_outputs();
	id_out_t o;
	o = '0;
	o.alu_op = ALU_NOP;
	o.ctrl.sign = 1'b1;
	return o;
endfunction

function automatic void decode_alu_fields(input logic [31:0] inst,
	output alu_op_e op, output exc_t exc);
	logic [5:0] opc;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	opc = inst[31:26];
	fn = inst[5:0];
	rs = inst[25:21];
	rt = inst[20:16];
	op = ALU_NOP;
	exc = '0;
	case (opc)
		// J, BEQ, BNE and PREF leave the ALU idle
		6'h02, 6'h04, 6'h05, 6'h33: op = ALU_NOP;
		6'h03: op = ALU_JALR;
		6'h06, 6'h07: exc.ri = (rt != 5'd0);
		6'h08: op = ALU_ADDI;
		6'h09: op = ALU_ADDIU;
		6'h0a: op = ALU_SLTI;
		6'h0b: op = ALU_SLTIU;
		6'h0c: op = ALU_ANDI;
		6'h0d: op = ALU_ORI;
		6'h0e: op = ALU_XORI;
		6'h0f:
		begin
			op = ALU_LU;
			exc.ri = (rs != 5'd0);
		end
		6'h20: op = ALU_LB;
		6'h21: op = ALU_LH;
		6'h23: op = ALU_LW;
		6'h24: op = ALU_LBU;
		6'h25: op = ALU_LHU;
		6'h28: op = ALU_SB;
		6'h29: op = ALU_SH;
		6'h2b: op = ALU_SW;
		6'h01:
		begin
			// only BLTZ, BGEZ and their link forms exist
			if (rt == 5'h10 || rt == 5'h11)
				op = ALU_JALR;
			else if (rt != 5'h00 && rt != 5'h01)
				exc.ri = 1'b1;
		end
		6'h1c:
		begin
			if (fn == 6'h02)
				op = ALU_MUL;
			else
				exc.ri = 1'b1;
		end
		6'h00:
		begin
			case (fn)
				6'h00: op = ALU_SLL;
				6'h02: op = ALU_SRL;
				6'h03: op = ALU_SRA;
				6'h04: op = ALU_SLLV;
				6'h06: op = ALU_SRLV;
				6'h07: op = ALU_SRAV;
				6'h09: op = ALU_JALR;
				6'h0c: exc.sys = 1'b1;
				6'h0d: exc.brk = 1'b1;
				// JR, SYNC and the divides have no ALU operation
				6'h08, 6'h0f, 6'h1a, 6'h1b: op = ALU_NOP;
				6'h10: op = ALU_MFHI;
				6'h11: op = ALU_MTHI;
				6'h12: op = ALU_MFLO;
				6'h13: op = ALU_MTLO;
				6'h18: op = ALU_MULT;
				6'h19: op = ALU_MULTU;
				6'h20: op = ALU_ADD;
				6'h21: op = ALU_ADDU;
				6'h22: op = ALU_SUB;
				6'h23: op = ALU_SUBU;
				6'h24: op = ALU_AND;
				6'h25: op = ALU_OR;
				6'h26: op = ALU_XOR;
				6'h27: op = ALU_NOR;
				6'h2a: op = ALU_SLT;
				6'h2b: op = ALU_SLTU;
				default: exc.ri = 1'b1;
			endcase
		end
		default: exc.ri = 1'b1;
	endcase
endfunction

function automatic ctrl_t build_ctrl_word(input logic [31:0] inst);
	ctrl_t c;
	logic [5:0] opc;
	logic [5:0] fn;
	logic [4:0] rt;
	opc = inst[31:26];
	fn = inst[5:0];
	rt = inst[20:16];
	c = '0;
	c.sign = 1'b1;
	case (opc)
		6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f:
		begin
			c.wreg = 1'b1;
			c.result_sel = RES_ALU;
			c.alusrc1_sel = SRC1_IMM;
			// ANDI and up take a zero extended immediate
			c.sign = (opc < 6'h0c);
		end
		6'h20, 6'h21, 6'h23, 6'h24, 6'h25:
		begin
			c.wreg = 1'b1;
			c.alusrc1_sel = SRC1_IMM;
			case (opc)
				6'h20: c.load_type = LD_LB;
				6'h21: c.load_type = LD_LH;
				6'h24: c.load_type = LD_LBU;
				6'h25: c.load_type = LD_LHU;
				default: c.load_type = LD_LW;
			endcase
		end
		6'h28, 6'h29, 6'h2b:
		begin
			c.wmem = 1'b1;
			c.alusrc1_sel = SRC1_IMM;
			case (opc)
				6'h28: c.store_type = ST_SB;
				6'h29: c.store_type = ST_SH;
				default: c.store_type = ST_SW;
			endcase
		end
		6'h03, 6'h01:
		begin
			if (opc == 6'h03 || rt == 5'h10 || rt == 5'h11)
			begin
				c.wreg = 1'b1;
				c.result_sel = RES_ALU;
				c.regdst = DST_RA;
			end
		end
		6'h1c:
		begin
			if (fn == 6'h02)
			begin
				c.wreg = 1'b1;
				c.result_sel = RES_ALU;
				c.regdst = DST_RD;
			end
		end
		6'h00:
		begin
			case (fn)
				6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h09, 6'h10, 6'h12,
				6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b:
				begin
					c.wreg = 1'b1;
					c.result_sel = RES_ALU;
					c.regdst = DST_RD;
					c.alusrc0_sel = (fn == 6'h00 || fn == 6'h02 || fn == 6'h03);
					if (fn == 6'h10)
						c.alusrc1_sel = SRC1_HI;
					else if (fn == 6'h12)
						c.alusrc1_sel = SRC1_LO;
				end
				6'h11, 6'h13:
				begin
					c.whi = (fn == 6'h11);
					c.wlo = (fn == 6'h13);
					c.result_sel = RES_ALU;
				end
				6'h18, 6'h19, 6'h1a, 6'h1b:
				begin
					c.hi_i_sel = 1'b1;
					c.lo_i_sel = 1'b1;
					c.whi = 1'b1;
					c.wlo = 1'b1;
					c.is_div = fn[1];
					c.is_sign_div = (fn == 6'h1a);
				end
				default: ;
			endcase
		end
		default: ;
	endcase
	return c;
endfunction

function automatic bj_t resolve_branch(input logic [31:0] inst,
	input logic [XLEN-1:0] pc4,
	input logic [XLEN-1:0] rs_d, input logic [XLEN-1:0] rt_d);
	bj_t b;
	logic signed [XLEN-1:0] rs_s;
	logic signed [XLEN-1:0] off;
	logic [XLEN-1:0] btgt;
	logic [XLEN-1:0] jtgt;
	logic is_b;
	logic cond;
	rs_s = $signed(rs_d);
	off = XLEN'($signed(inst[15:0]));
	btgt = pc4 + (off <<< 2);
	jtgt = (pc4 & 32'hf000_0000) | {4'h0, inst[25:0], 2'b00};
	b = '0;
	is_b = 1'b0;
	cond = 1'b0;
	case (inst[31:26])
		6'h02, 6'h03:
		begin
			b.i_bj = 1'b1;
			b.taken = 1'b1;
			b.target = jtgt;
		end
		6'h04:
		begin
			is_b = 1'b1;
			cond = (rs_d == rt_d);
		end
		6'h05:
		begin
			is_b = 1'b1;
			cond = (rs_d != rt_d);
		end
		6'h06:
		begin
			is_b = 1'b1;
			cond = (rs_s <= 0);
		end
		6'h07:
		begin
			is_b = 1'b1;
			cond = (rs_s > 0);
		end
		6'h01:
		begin
			is_b = (inst[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11});
			cond = inst[16] ? (rs_s >= 0) : (rs_s < 0);
		end
		6'h00:
		begin
			// JR and JALR
			if (inst[5:0] == 6'h08 || inst[5:0] == 6'h09)
			begin
				b.i_bj = 1'b1;
				b.i_b = 1'b1;
				b.taken = 1'b1;
				b.target = rs_d;
			end
		end
		default: ;
	endcase
	if (is_b)
	begin
		b.i_bj = 1'b1;
		b.i_b = 1'b1;
		b.taken = cond;
		b.target = btgt;
	end
	return b;
endfunction

function automatic id_out_t expected_outputs(input logic [31:0] inst,
	input logic [XLEN-1:0] pc4,
	input logic [XLEN-1:0] rs_d, input logic [XLEN-1:0] rt_d, input logic ds);
	id_out_t o;
	alu_op_e op;
	exc_t exc;
	decode_alu_fields(inst, op, exc);
	o.valid = 1'b1;
	o.alu_op = op;
	o.exc = exc;
	o.ctrl = build_ctrl_word(inst);
	o.bj = resolve_branch(inst, pc4, rs_d, rt_d);
	o.delayslot = ds;
	return o;
endfunction

`endif

/* bench/tb_id_stage.sv */
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import id_pkg::*;

	`include "id_model.svh"

	localparam int N_INST = 2000;
	localparam int RST_CYC = 3;
	// run length plus slack for reset and drain
	localparam int TIMEOUT_CYC = N_INST + 100;

	// kept primary opcodes padded with extra branches
	localparam logic [5:0] OP_TAB [0:31] = '{
		6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
		6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
		6'h1c, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29,
		6'h2b, 6'h33, 6'h01, 6'h01, 6'h04, 6'h05, 6'h06, 6'h07
	};
	// kept SPECIAL function codes padded with jumps and DIV
	localparam logic [5:0] FN_TAB [0:31] = '{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
		6'h0c, 6'h0d, 6'h0f, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18,
		6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
		6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b, 6'h09, 6'h08, 6'h1a
	};
	localparam logic [4:0] RT_TAB [0:3] = '{5'h00, 5'h01, 5'h10, 5'h11};

	logic            clk;
	logic            rst_n;
	logic            i_valid;
	logic [31:0]     i_inst;
	logic [XLEN-1:0] i_pc_plus4;
	logic [XLEN-1:0] i_rs_data;
	logic [XLEN-1:0] i_rt_data;
	logic            i_delayslot;
	logic            o_valid;
	alu_op_e         o_alu_op;
	ctrl_t           o_ctrl;
	bj_t             o_bj;
	exc_t            o_exc;
	logic            o_delayslot;

	int      seed = 44;
	int      cycle_cnt = 0;
	id_out_t exp_q[$];

	id_stage #(
		.DATA_W (XLEN)
	) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_valid     (i_valid),
		.i_inst      (i_inst),
		.i_pc_plus4  (i_pc_plus4),
		.i_rs_data   (i_rs_data),
		.i_rt_data   (i_rt_data),
		.i_delayslot (i_delayslot),
		.o_valid     (o_valid),
		.o_alu_op    (o_alu_op),
		.o_ctrl      (o_ctrl),
		.o_bj        (o_bj),
		.o_exc       (o_exc),
		.o_delayslot (o_delayslot)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		$display("FAIL time %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
		$display("Test failures found");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic compare_outputs(input id_out_t e);
		assert (o_valid === e.valid)
			else report_mismatch("o_valid", 64'(e.valid), 64'(o_valid));
		assert (o_alu_op === e.alu_op)
			else report_mismatch("o_alu_op", 64'(e.alu_op), 64'(o_alu_op));
		assert (o_ctrl === e.ctrl)
			else report_mismatch("o_ctrl", 64'(e.ctrl), 64'(o_ctrl));
		assert (o_bj.i_bj === e.bj.i_bj)
			else report_mismatch("o_bj.i_bj", 64'(e.bj.i_bj), 64'(o_bj.i_bj));
		assert (o_bj.i_b === e.bj.i_b)
			else report_mismatch("o_bj.i_b", 64'(e.bj.i_b), 64'(o_bj.i_b));
		assert (o_bj.taken === e.bj.taken)
			else report_mismatch("o_bj.taken", 64'(e.bj.taken), 64'(o_bj.taken));
		assert (o_bj.target === e.bj.target)
			else report_mismatch("o_bj.target", 64'(e.bj.target), 64'(o_bj.target));
		assert (o_exc === e.exc)
			else report_mismatch("o_exc", 64'(e.exc), 64'(o_exc));
		assert (o_delayslot === e.delayslot)
			else report_mismatch("o_delayslot", 64'(e.delayslot), 64'(o_delayslot));
	endtask

	// one in five words stays fully random
	task automatic make_instr(output logic [31:0] inst);
		logic [31:0] sel;
		logic [31:0] r;
		inst = $random(seed);
		sel = $random(seed);
		r = $random(seed);
		if (sel % 100 < 40)
		begin
			inst[31:26] = 6'h00;
			inst[5:0] = FN_TAB[r[4:0]];
		end
		else if (sel % 100 < 80)
		begin
			inst[31:26] = OP_TAB[r[4:0]];
			case (inst[31:26])
				6'h01: inst[20:16] = RT_TAB[r[6:5]];
				6'h1c:
				begin
					if (r[8])
						inst[5:0] = 6'h02;
				end
				// half of BLEZ/BGTZ and LUI get the legal zero field
				6'h06, 6'h07:
				begin
					if (r[9])
						inst[20:16] = 5'd0;
				end
				6'h0f:
				begin
					if (r[9])
						inst[25:21] = 5'd0;
				end
				default: ;
			endcase
		end
	endtask

	task automatic make_operands(output logic [XLEN-1:0] rs, output logic [XLEN-1:0] rt);
		logic [31:0] k;
		rs = $random(seed);
		rt = $random(seed);
		k = $random(seed);
		case (k[2:0])
			3'd0: rt = rs;
			3'd1: rs = '0;
			default: ;
		endcase
	endtask

	initial
	begin
		id_out_t         e;
		logic [31:0]     inst;
		logic [XLEN-1:0] rs;
		logic [XLEN-1:0] rt;
		logic [XLEN-1:0] pc4;
		logic [31:0]     r;
		logic            v;
		logic            ds;
		rst_n = 1'b0;
		i_valid = 1'b0;
		i_inst = '0;
		i_pc_plus4 = '0;
		i_rs_data = '0;
		i_rt_data = '0;
		i_delayslot = 1'b0;
		for (int cyc = 0; cyc <= RST_CYC + N_INST; cyc++)
		begin
			@(posedge clk);
			inst = '0;
			rs = '0;
			rt = '0;
			pc4 = '0;
			v = 1'b0;
			ds = 1'b0;
			if (cyc >= RST_CYC && cyc < RST_CYC + N_INST)
			begin
				make_instr(inst);
				make_operands(rs, rt);
				r = $random(seed);
				pc4 = {r[31:2], 2'b00};
				r = $random(seed);
				v = (r % 10 != 0);
				ds = r[31];
			end
			rst_n <= (cyc >= RST_CYC);
			i_valid <= v;
			i_inst <= inst;
			i_pc_plus4 <= pc4;
			i_rs_data <= rs;
			i_rt_data <= rt;
			i_delayslot <= ds;
			if (cyc < RST_CYC || !v)
				e = idle_outputs();
			else
				e = expected_outputs(inst, pc4, rs, rt, ds);
			exp_q.push_back(e);
			// outputs now hold what the DUT took one edge earlier
			@(negedge clk);
			if (exp_q.size() > 1)
				compare_outputs(exp_q.pop_front());
		end
		$display("All tests passed!");
		$finish;
	end

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

endmodule

/* verilog.f */
+incdir+bench
hw/id_pkg.sv
hw/alu_op_decode.sv
hw/ctrl_decode.sv
hw/branch_unit.sv
hw/id_stage.sv
bench/tb_id_stage.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module tb_id_stage -Mdir obj_dir -o sim_id_stage
	./obj_dir/sim_id_stage | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
